// ==== hw/mem_data_pkg.sv ====
/*
  Shared widths, control bit positions and types for the memory data
  and parity transceiver: byte, bus and memory word vectors, the lane
  memory struct, the control bundle and the lane error vector
*/
`default_nettype none

package mem_data_pkg;

  // Word geometry
  localparam int NUM_LANES     = 2;              // Bytes per word
  localparam int LANE_BITS     = 8;              // Data bits per byte
  localparam int MEM_LANE_BITS = LANE_BITS + 1;  // Byte plus its parity bit

  // Control register bit positions on the local bus
  localparam int CTRL_DISABLE_BIT = 0;  // Parity check disable
  localparam int CTRL_CLEAR_BIT   = 1;  // Error clear request

  typedef logic [LANE_BITS-1:0]               lane_byte_t;  // One data byte
  typedef logic [NUM_LANES*LANE_BITS-1:0]     bus_word_t;   // CPU local bus word
  typedef logic [NUM_LANES*MEM_LANE_BITS-1:0] mem_word_t;   // Memory word with parity

  // Memory side of one lane, parity on top
  typedef struct packed {
    logic       parity;  // Odd parity over the byte
    lane_byte_t data;
  } lane_mem_t;

  // Decoded strobes shared by the lanes and the collector
  typedef struct packed {
    logic mem_drive;     // Drive the memory data bus
    logic bus_drive;     // Drive the CPU local bus
    logic capture;       // Read capture strobe
    logic check_enable;  // Parity checking active
    logic clear_errors;  // One cycle error clear
  } lane_ctrl_t;

  // One sticky error per lane, bit 0 is the low byte
  typedef logic [NUM_LANES-1:0] lane_err_t;

endpackage : mem_data_pkg

`default_nettype wire

// ==== hw/parity_control.sv ====
/*
  Parity control register and strobe decoder
  Holds the check disable bit and the registered error clear pulse,
  both loaded by I/O expansion writes, and decodes the bus drive
  enables, the read capture strobe and the check enable
*/
`timescale 1ns/1ps
`default_nettype none

module parity_control
  import mem_data_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  input  wire        mem_write,       // Memory write cycle
  input  wire        iox_enable,      // I/O expansion access
  input  wire        ecc_request,     // ECC owns this read
  input  wire        cpu_grant_read,  // CPU granted the read data
  input  wire        read_strobe,     // Memory read data valid
  input  bus_word_t  bus_data_in,     // Local bus, control data on writes
  output lane_ctrl_t ctrl
);

  logic ctrl_write;     // Control register write cycle
  logic disable_q;      // Stored parity check disable
  logic clear_q;        // Registered clear pulse
  logic clear_request;  // Clear bit set on a control write

  // IOX write reaches the control register, not memory
  assign ctrl_write    = iox_enable & mem_write;
  assign clear_request = ctrl_write & bus_data_in[CTRL_CLEAR_BIT];

  // Disable bit, rewritten by every control write
  always_ff @(posedge clock) begin
    if (reset) begin
      disable_q <= 1'b0;  // Checking on after reset
    end else if (ctrl_write) begin
      disable_q <= bus_data_in[CTRL_DISABLE_BIT];
    end
  end

  // Clear pulse lasts exactly one cycle after the write
  always_ff @(posedge clock) begin
    if (reset) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= clear_request;  // Drops again unless another write follows
    end
  end

  // Drive and capture decode
  always_comb begin
    ctrl.mem_drive    = mem_write & ~iox_enable;     // Plain memory write only
    ctrl.bus_drive    = cpu_grant_read & ~mem_write; // Read data to CPU
    ctrl.capture      = read_strobe & ~mem_write;    // No capture on writes
    // Suppressed by the disable bit or an ECC read
    ctrl.check_enable = ~disable_q & ~ecc_request;
    ctrl.clear_errors = clear_q;
  end

endmodule : parity_control

`default_nettype wire

// ==== hw/parity_lane.sv ====
/*
  One byte lane of the transceiver
  Write side generates odd parity for the outgoing byte, read side
  captures the memory byte and checks its parity into a sticky error
*/
`timescale 1ns/1ps
`default_nettype none

module parity_lane
  import mem_data_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  input  lane_ctrl_t ctrl,          // Decoded strobes
  input  lane_byte_t bus_byte,      // Byte from the local bus
  input  lane_mem_t  mem_lane,      // Byte and parity from memory
  output lane_byte_t bus_byte_out,  // Captured read byte
  output lane_mem_t  mem_lane_out,  // Byte and parity to memory
  output logic       lane_error     // Sticky parity error
);

  lane_byte_t captured_q;  // Read capture register
  logic       read_ones;   // XOR of all nine read bits
  logic       parity_bad;  // Even count of ones seen
  logic       error_q;

  // Write path, purely combinational
  // Parity bit makes the nine bits odd
  always_comb begin
    mem_lane_out.data   = bus_byte;
    mem_lane_out.parity = ~(^bus_byte);
  end

  // Odd parity expected, so a zero XOR is a failure
  assign read_ones  = ^{mem_lane.parity, mem_lane.data};
  assign parity_bad = ~read_ones;

  // Read capture, newest strobe simply overwrites
  always_ff @(posedge clock) begin
    if (reset) begin
      captured_q <= '0;
    end else if (ctrl.capture) begin
      captured_q <= mem_lane.data;
    end
  end

  assign bus_byte_out = captured_q;  // Shown from the cycle after the strobe

  // Sticky lane error
  // Checked on the capture edge itself
  // A set in the clear cycle wins over the clear
  always_ff @(posedge clock) begin
    if (reset) begin
      error_q <= 1'b0;
    end else if (ctrl.capture && ctrl.check_enable && parity_bad) begin
      error_q <= 1'b1;
    end else if (ctrl.clear_errors) begin
      error_q <= 1'b0;
    end
  end

  assign lane_error = error_q;

endmodule : parity_lane

`default_nettype wire

// ==== hw/error_collector.sv ====
/*
  Parity error collector
  Names the low and high byte errors, forms the local error and keeps
  the sticky local parity error and the parity LED flag
*/
`timescale 1ns/1ps
`default_nettype none

module error_collector
  import mem_data_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  input  lane_ctrl_t ctrl,                // Check enable and error clear
  input  lane_err_t  errors,              // Sticky lane errors
  output logic       lo_error,            // Low byte error
  output logic       hi_error,            // High byte error
  output logic       local_error,         // Either byte failed
  output logic       local_parity_error,  // Sticky, cleared by error clear
  output logic       parity_led           // Sticky, survives error clear
);

  logic lperr_q;
  logic led_q;

  // Lane 0 is the low byte, lane 1 the high byte
  assign lo_error    = errors[0];
  assign hi_error    = errors[1];
  assign local_error = |errors;

  // Local parity error, one cycle behind local_error
  // Clear takes priority, lane errors are still up in the clear cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      lperr_q <= 1'b0;
    end else if (ctrl.clear_errors) begin
      lperr_q <= 1'b0;
    end else if (local_error) begin
      lperr_q <= 1'b1;
    end
  end

  // LED flag ignores the error clear
  // Dropped once checking is switched off
  always_ff @(posedge clock) begin
    if (reset) begin
      led_q <= 1'b0;
    end else if (!ctrl.check_enable) begin
      led_q <= 1'b0;  // Parity disabled
    end else if (local_error) begin
      led_q <= 1'b1;
    end
  end

  assign local_parity_error = lperr_q;
  assign parity_led         = led_q;

endmodule : error_collector

`default_nettype wire

// ==== hw/mem_data_path.sv ====
/*
  Memory data and parity transceiver, top level
  Control decoder, one parity lane per byte and the error collector
*/
`timescale 1ns/1ps
`default_nettype none

module mem_data_path
  import mem_data_pkg::*;
(
  input  wire       clock,
  input  wire       reset,
  input  wire       mem_write,           // Memory write cycle
  input  wire       iox_enable,          // I/O expansion access
  input  wire       ecc_request,         // ECC owns this read
  input  wire       cpu_grant_read,      // CPU granted the read data
  input  wire       read_strobe,         // Memory read data valid
  input  bus_word_t bus_data_in,         // From the CPU local bus
  input  mem_word_t mem_data_in,         // From the memory data bus
  output bus_word_t bus_data_out,        // Captured read word
  output logic      bus_drive,           // Local bus drive enable
  output mem_word_t mem_data_out,        // Write word with parity
  output logic      mem_drive,           // Memory bus drive enable
  output logic      lo_error,
  output logic      hi_error,
  output logic      local_error,
  output logic      local_parity_error,
  output logic      parity_led
);

  lane_ctrl_t ctrl;    // Decoded strobes to lanes and collector
  lane_err_t  errors;  // One sticky error per lane

  parity_control u_control (
    .clock          (clock),
    .reset          (reset),
    .mem_write      (mem_write),
    .iox_enable     (iox_enable),
    .ecc_request    (ecc_request),
    .cpu_grant_read (cpu_grant_read),
    .read_strobe    (read_strobe),
    .bus_data_in    (bus_data_in),
    .ctrl           (ctrl)
  );

  assign mem_drive = ctrl.mem_drive;
  assign bus_drive = ctrl.bus_drive;

  // Byte lanes, lane i owns bus byte i and memory bits 9i+8..9i
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    parity_lane u_lane (
      .clock        (clock),
      .reset        (reset),
      .ctrl         (ctrl),
      .bus_byte     (bus_data_in[i*LANE_BITS +: LANE_BITS]),
      .mem_lane     (lane_mem_t'(mem_data_in[i*MEM_LANE_BITS +: MEM_LANE_BITS])),
      .bus_byte_out (bus_data_out[i*LANE_BITS +: LANE_BITS]),
      .mem_lane_out (mem_data_out[i*MEM_LANE_BITS +: MEM_LANE_BITS]),
      .lane_error   (errors[i])
    );
  end

  error_collector u_collector (
    .clock              (clock),
    .reset              (reset),
    .ctrl               (ctrl),
    .errors             (errors),
    .lo_error           (lo_error),
    .hi_error           (hi_error),
    .local_error        (local_error),
    .local_parity_error (local_parity_error),
    .parity_led         (parity_led)
  );

endmodule : mem_data_path

`default_nettype wire

// ==== verif/mem_data_path_tb.sv ====
/*
  Testbench for the memory data and parity transceiver
  Clock and reset, LFSR stimulus, cycle model of lanes and flags,
  typed compare tasks, watchdog and closing summary
*/
`timescale 1ns/1ps
`default_nettype none

module mem_data_path_tb
  import mem_data_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 2;
  localparam int WRITE_CYCLES  = 16;   // Write parity test
  localparam int READ_CYCLES   = 16;   // Clean read test
  localparam int FIXED_CYCLES  = 23;   // Reset, bad parity, clear, suppression
  localparam int RANDOM_CYCLES = 200;  // Mixed traffic at the end
  localparam int MARGIN_CYCLES = 40;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + WRITE_CYCLES + READ_CYCLES
                               + FIXED_CYCLES + RANDOM_CYCLES;
  localparam int TIMEOUT_NS    = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'h391e_f88e;

  // DUT ports
  logic      clock;
  logic      reset;
  logic      mem_write;
  logic      iox_enable;
  logic      ecc_request;
  logic      cpu_grant_read;
  logic      read_strobe;
  bus_word_t bus_data_in;
  mem_word_t mem_data_in;
  bus_word_t bus_data_out;
  logic      bus_drive;
  mem_word_t mem_data_out;
  logic      mem_drive;
  logic      lo_error;
  logic      hi_error;
  logic      local_error;
  logic      local_parity_error;
  logic      parity_led;

  // Reference model state
  logic      m_disable;   // Stored check disable
  logic      m_clear;     // Registered clear pulse
  bus_word_t m_captured;  // Captured read bytes
  lane_err_t m_err;       // Sticky lane errors
  logic      m_lperr;
  logic      m_led;

  logic [31:0] lfsr_state;
  int          error_count;
  int          check_count;

  mem_data_path dut (
    .clock              (clock),
    .reset              (reset),
    .mem_write          (mem_write),
    .iox_enable         (iox_enable),
    .ecc_request        (ecc_request),
    .cpu_grant_read     (cpu_grant_read),
    .read_strobe        (read_strobe),
    .bus_data_in        (bus_data_in),
    .mem_data_in        (mem_data_in),
    .bus_data_out       (bus_data_out),
    .bus_drive          (bus_drive),
    .mem_data_out       (mem_data_out),
    .mem_drive          (mem_drive),
    .lo_error           (lo_error),
    .hi_error           (hi_error),
    .local_error        (local_error),
    .local_parity_error (local_parity_error),
    .parity_led         (parity_led)
  );

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic feedback;
    feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], feedback};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < count; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};  // Newest feedback bit
    end
    return value;
  endfunction

  // Parity bit that makes byte plus parity odd
  function automatic logic odd_parity_bit(input lane_byte_t b);
    int ones;
    ones = 0;
    for (int k = 0; k < LANE_BITS; k++) begin
      if (b[k]) ones++;
    end
    return (ones % 2 == 0);
  endfunction

  function automatic logic nine_bits_odd(input logic [MEM_LANE_BITS-1:0] nine);
    int ones;
    ones = 0;
    for (int k = 0; k < MEM_LANE_BITS; k++) begin
      if (nine[k]) ones++;
    end
    return (ones % 2 == 1);
  endfunction

  // Memory word with good parity except on flipped lanes
  function automatic mem_word_t make_mem_word(input bus_word_t data, input lane_err_t flip);
    mem_word_t  word;
    lane_byte_t b;
    word = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      b = data[i*LANE_BITS +: LANE_BITS];
      word[i*MEM_LANE_BITS +: MEM_LANE_BITS] = {odd_parity_bit(b) ^ flip[i], b};
    end
    return word;
  endfunction

  function automatic lane_err_t one_lane_flip();
    if (take_bits(1) == 32'd1) return 2'b10;
    return 2'b01;
  endfunction

  task automatic check_bus_word(input string name, input bus_word_t got, input bus_word_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
      error_count++;
    end
  endtask

  task automatic check_mem_word(input string name, input mem_word_t got, input mem_word_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
      error_count++;
    end
  endtask

  task automatic check_enables(input logic got_mem, input logic got_bus,
                               input logic exp_mem, input logic exp_bus);
    check_count++;
    if (got_mem !== exp_mem) begin
      $display("Fail mem_drive at %0t: got 0x%h expected 0x%h", $time, got_mem, exp_mem);
      error_count++;
    end
    if (got_bus !== exp_bus) begin
      $display("Fail bus_drive at %0t: got 0x%h expected 0x%h", $time, got_bus, exp_bus);
      error_count++;
    end
  endtask

  // Lane errors plus the three flags
  task automatic check_errors(input lane_err_t got_lanes, input logic got_local,
                              input logic got_lperr, input logic got_led,
                              input lane_err_t exp_lanes, input logic exp_local,
                              input logic exp_lperr, input logic exp_led);
    check_count++;
    if (got_lanes !== exp_lanes) begin
      $display("Fail {hi_error,lo_error} at %0t: got 0x%h expected 0x%h",
               $time, got_lanes, exp_lanes);
      error_count++;
    end
    if (got_local !== exp_local) begin
      $display("Fail local_error at %0t: got 0x%h expected 0x%h", $time, got_local, exp_local);
      error_count++;
    end
    if (got_lperr !== exp_lperr) begin
      $display("Fail local_parity_error at %0t: got 0x%h expected 0x%h",
               $time, got_lperr, exp_lperr);
      error_count++;
    end
    if (got_led !== exp_led) begin
      $display("Fail parity_led at %0t: got 0x%h expected 0x%h", $time, got_led, exp_led);
      error_count++;
    end
  endtask

  // Fixed expectation on the registered flags
  task automatic expect_flags(input lane_err_t lanes, input logic lperr, input logic led);
    check_errors({hi_error, lo_error}, local_error, local_parity_error, parity_led,
                 lanes, |lanes, lperr, led);
  endtask

  // Everything the DUT shows mid cycle
  task automatic check_outputs();
    check_mem_word("mem_data_out", mem_data_out, make_mem_word(bus_data_in, '0));
    check_bus_word("bus_data_out", bus_data_out, m_captured);
    check_enables(mem_drive, bus_drive, mem_write & ~iox_enable, cpu_grant_read & ~mem_write);
    check_errors({hi_error, lo_error}, local_error, local_parity_error, parity_led,
                 m_err, |m_err, m_lperr, m_led);
  endtask

  // Model state update at the rising edge from the old state
  task automatic update_model();
    logic check_en;
    logic capture;
    logic any_err;
    logic ctrl_write;
    logic [MEM_LANE_BITS-1:0] nine;
    check_en   = ~m_disable & ~ecc_request;
    capture    = read_strobe & ~mem_write;
    any_err    = |m_err;
    ctrl_write = iox_enable & mem_write;
    if (m_clear) m_lperr = 1'b0;       // Clear beats set here
    else if (any_err) m_lperr = 1'b1;
    if (!check_en) m_led = 1'b0;
    else if (any_err) m_led = 1'b1;
    for (int i = 0; i < NUM_LANES; i++) begin
      nine = mem_data_in[i*MEM_LANE_BITS +: MEM_LANE_BITS];
      if (capture && check_en && !nine_bits_odd(nine)) m_err[i] = 1'b1;  // Set wins
      else if (m_clear) m_err[i] = 1'b0;
      if (capture) m_captured[i*LANE_BITS +: LANE_BITS] = nine[LANE_BITS-1:0];
    end
    if (ctrl_write) m_disable = bus_data_in[CTRL_DISABLE_BIT];
    m_clear = ctrl_write & bus_data_in[CTRL_CLEAR_BIT];
  endtask

  // Runs from 2 ns after one edge to 2 ns after the next
  task automatic apply_cycle(input logic mw, input logic iox, input logic ecc,
                             input logic grant, input logic rs,
                             input bus_word_t bd, input mem_word_t md);
    mem_write      = mw;
    iox_enable     = iox;
    ecc_request    = ecc;
    cpu_grant_read = grant;
    read_strobe    = rs;
    bus_data_in    = bd;
    mem_data_in    = md;
    #(CLK_PERIOD / 2 - 2);  // Falling edge, all settled
    check_outputs();
    @(posedge clock);
    update_model();
    #2;
  endtask

  task automatic idle_cycle();
    apply_cycle(1'b0, 1'b0, 1'b0, take_bits(1) == 32'd1, 1'b0,
                bus_word_t'(take_bits(16)), mem_word_t'(take_bits(18)));
  endtask

  // Read with chosen parity flips
  task automatic read_cycle(input lane_err_t flip, input logic ecc);
    apply_cycle(1'b0, 1'b0, ecc, take_bits(1) == 32'd1, 1'b1, '0,
                make_mem_word(bus_word_t'(take_bits(16)), flip));
  endtask

  task automatic control_write(input bus_word_t value);
    apply_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, value, '0);
  endtask

  initial begin
    lfsr_state     = SEED;
    error_count    = 0;
    check_count    = 0;
    reset          = 1'b1;
    mem_write      = 1'b0;
    iox_enable     = 1'b0;
    ecc_request    = 1'b0;
    cpu_grant_read = 1'b0;
    read_strobe    = 1'b1;  // Bad parity reads held through reset
    bus_data_in    = '0;
    mem_data_in    = make_mem_word(bus_word_t'(take_bits(16)), '1);
    m_disable      = 1'b0;
    m_clear        = 1'b0;
    m_captured     = '0;
    m_err          = '0;
    m_lperr        = 1'b0;
    m_led          = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;

    // Reset state
    check_bus_word("bus_data_out", bus_data_out, '0);
    expect_flags('0, 1'b0, 1'b0);
    idle_cycle();

    // Write parity over mostly write cycles
    for (int n = 0; n < WRITE_CYCLES; n++) begin
      apply_cycle(take_bits(2) != 32'd0, 1'b0, 1'b0, take_bits(1) == 32'd1, 1'b0,
                  bus_word_t'(take_bits(16)), mem_word_t'(take_bits(18)));
    end

    // Clean reads
    for (int n = 0; n < READ_CYCLES; n++) begin
      read_cycle('0, 1'b0);
    end
    expect_flags('0, 1'b0, 1'b0);

    // Bad parity on one lane with flags one cycle later and sticky over clean reads
    begin
      lane_err_t flip;
      flip = one_lane_flip();
      read_cycle(flip, 1'b0);
      expect_flags(flip, 1'b0, 1'b0);
      idle_cycle();
      expect_flags(flip, 1'b1, 1'b1);
      for (int n = 0; n < 4; n++) begin
        read_cycle('0, 1'b0);
      end
      expect_flags(flip, 1'b1, 1'b1);
    end

    // Error clear leaves the LED set
    control_write(bus_word_t'(1 << CTRL_CLEAR_BIT));
    idle_cycle();
    expect_flags('0, 1'b0, 1'b1);

    // Disable bit drops the LED and blocks checks
    read_cycle(one_lane_flip(), 1'b0);
    idle_cycle();
    control_write(bus_word_t'((1 << CTRL_DISABLE_BIT) | (1 << CTRL_CLEAR_BIT)));
    idle_cycle();
    expect_flags('0, 1'b0, 1'b0);
    for (int n = 0; n < 4; n++) begin
      read_cycle(one_lane_flip(), 1'b0);
    end
    expect_flags('0, 1'b0, 1'b0);

    // Checks back on but ECC reads still suppressed
    control_write('0);
    for (int n = 0; n < 4; n++) begin
      read_cycle(one_lane_flip(), 1'b1);
    end
    idle_cycle();
    expect_flags('0, 1'b0, 1'b0);

    // Mixed random traffic against the model
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      lane_err_t flip;
      flip = (take_bits(2) == 32'd0) ? lane_err_t'(take_bits(2)) : '0;
      apply_cycle(take_bits(1) == 32'd1, take_bits(3) == 32'd0, take_bits(2) == 32'd0,
                  take_bits(1) == 32'd1, take_bits(1) == 32'd1,
                  bus_word_t'(take_bits(16)),
                  make_mem_word(bus_word_t'(take_bits(16)), flip));
    end

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run still going after %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule : mem_data_path_tb

`default_nettype wire

// ==== mem_data_path.f ====
hw/mem_data_pkg.sv
hw/parity_control.sv
hw/parity_lane.sv
hw/error_collector.sv
hw/mem_data_path.sv
verif/mem_data_path_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory data path testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= mem_data_path_tb
FILELIST  ?= mem_data_path.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Result: FAIL"; \
	  exit 1; \
	else \
	  echo "Result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
